//--- verif/write_patterns.txt
// src_x src_y tag address len size data_seed strobe bresp, all hex
// beat i of a burst carries data_seed + i, len is beats minus one
0 0 0 00001000 00 2 a5a50000 f 0
1 0 1 00001040 03 2 12340000 f 0
0 1 2 00002000 01 2 00000010 3 1
3 3 3 00002100 07 2 deadbe00 f 2
2 2 4 00003000 00 1 55aa0000 c 0
1 1 5 00003020 02 2 01010100 f 3
0 3 6 00004000 0f 2 cafe0000 f 0
3 0 7 00004400 00 0 000000ff 1 0
2 1 8 00005000 01 2 77770000 a 1
1 2 9 00005080 04 2 10000000 f 0
0 0 a 00006000 02 1 0000abc0 3 2
3 1 b 00006100 00 2 fffffff0 f 0
2 3 c 00007000 05 2 00c0ffee f 0
1 0 d 00007200 01 2 31415900 5 3
0 2 e 00008000 03 2 27182800 f 0
3 2 f 00008040 00 2 ffffffff f 1
2 0 0 00009000 06 2 0badf000 f 0
1 3 1 00009100 02 2 13579bd0 9 0
0 1 2 0000a000 00 1 24680000 3 2
3 3 3 0000a040 03 2 a0a0a0a0 f 0
2 2 4 0000b000 01 2 5a5a5a5a f 3
1 1 5 0000b080 00 0 00000042 4 0
0 3 6 0000c000 02 2 76543210 f 1
3 0 7 0000c100 07 2 fedcba90 f 0
2 1 8 0000d000 00 2 00000000 f 0
1 2 9 0000d040 01 2 11223340 6 2
0 0 a 0000e000 03 2 99887760 f 0
3 1 b 0000e200 02 1 00004440 c 1
2 3 c 0000f000 00 2 80000000 f 0
1 0 d 0000f040 04 2 3c3c3c3c f 3
0 2 e 00010000 01 2 e0e0e0e0 f 0
3 2 f 00010100 02 2 0f0f0f00 b 0
2 0 0 00011000 00 2 abcdef00 f 2
1 3 1 00011040 03 2 00010000 f 0

//--- sim.f
+incdir+hw
hw/noc_axi_pkg.sv
hw/noc_packet_if.sv
hw/noc_packet_deserializer.sv
hw/noc_packet_serializer.sv
hw/noc_axi_write_adapter.sv
verif/tb_noc_axi_write_adapter.sv

//--- Bender.yml
package:
  name: noc_axi_write_adapter

export_include_dirs:
  - hw

sources:
  - hw/noc_axi_pkg.sv
  - hw/noc_packet_if.sv
  - hw/noc_packet_deserializer.sv
  - hw/noc_packet_serializer.sv
  - hw/noc_axi_write_adapter.sv
  - target: simulation
    files:
      - verif/tb_noc_axi_write_adapter.sv

//--- verif/tb_noc_axi_write_adapter.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_axi_defines.svh"

module tb_noc_axi_write_adapter;
  import noc_axi_pkg::*;

  localparam int NUM_PATTERNS = 34;
  localparam int NUM_FIELDS   = 9;
  localparam logic [`NOC_COORD_WIDTH-1:0] ID_X = 2'd2;
  localparam logic [`NOC_COORD_WIDTH-1:0] ID_Y = 2'd1;
  localparam logic [`NOC_VC_WIDTH-1:0]    VC   = 1'b1;

  logic                          clk;
  logic                          reset;
  logic                          rx_valid, rx_ready;
  noc_flit                       rx_flit;
  logic                          tx_valid, tx_ready;
  noc_flit                       tx_flit;
  logic                          awvalid, awready;
  logic [`NOC_AXI_ID_WIDTH-1:0]  awid;
  logic [`NOC_ADDR_WIDTH-1:0]    awaddr;
  logic [`NOC_LEN_WIDTH-1:0]     awlen;
  logic [2:0]                    awsize;
  logic [1:0]                    awburst;
  logic                          wvalid, wready, wlast;
  logic [`NOC_DATA_WIDTH-1:0]    wdata;
  logic [`NOC_STRB_WIDTH-1:0]    wstrb;
  logic                          bvalid, bready;
  logic [`NOC_AXI_ID_WIDTH-1:0]  bid;
  logic [1:0]                    bresp;

  // Nine raw file words per request
  logic [31:0]                   pattern_mem [NUM_PATTERNS*NUM_FIELDS];
  logic [`NOC_COORD_WIDTH-1:0]   src_x [NUM_PATTERNS];
  logic [`NOC_COORD_WIDTH-1:0]   src_y [NUM_PATTERNS];
  logic [`NOC_TAG_WIDTH-1:0]     tag [NUM_PATTERNS];
  logic [`NOC_ADDR_WIDTH-1:0]    addr [NUM_PATTERNS];
  logic [`NOC_LEN_WIDTH-1:0]     len [NUM_PATTERNS];
  logic [2:0]                    size [NUM_PATTERNS];
  logic [`NOC_DATA_WIDTH-1:0]    seed [NUM_PATTERNS];
  logic [`NOC_STRB_WIDTH-1:0]    strb [NUM_PATTERNS];
  logic [1:0]                    resp [NUM_PATTERNS];
  logic [`NOC_AXI_ID_WIDTH-1:0]  captured_awid [NUM_PATTERNS];

  int          error_count;
  int          aw_count, w_burst_count, w_beat_index, w_beat_total;
  int          b_count, resp_count, expected_beats;
  int          cycle_count, timeout_limit;
  logic        head_seen, idle_bit;
  logic [31:0] lfsr_state;

  always #2 clk = ~clk;

  noc_axi_write_adapter dut (
    .i_clk           (clk),
    .i_reset         (reset),
    .i_id_x          (ID_X),
    .i_id_y          (ID_Y),
    .i_vc            (VC),
    .i_rx_flit_valid (rx_valid),
    .i_rx_flit       (rx_flit),
    .o_rx_flit_ready (rx_ready),
    .o_tx_flit_valid (tx_valid),
    .o_tx_flit       (tx_flit),
    .i_tx_flit_ready (tx_ready),
    .o_awvalid       (awvalid),
    .i_awready       (awready),
    .o_awid          (awid),
    .o_awaddr        (awaddr),
    .o_awlen         (awlen),
    .o_awsize        (awsize),
    .o_awburst       (awburst),
    .o_wvalid        (wvalid),
    .i_wready        (wready),
    .o_wdata         (wdata),
    .o_wstrb         (wstrb),
    .o_wlast         (wlast),
    .i_bvalid        (bvalid),
    .o_bready        (bready),
    .i_bid           (bid),
    .i_bresp         (bresp)
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic random_bit(output logic value);
    lfsr_state = lfsr_next(lfsr_state);
    value      = lfsr_state[0];
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
    error_count++;
  endtask

  task automatic report_failure(input string what);
    $display("Error: %s", what);
    error_count++;
  endtask

  task automatic finish_run();
    $display("Errors %0d, AW beats %0d, W beats %0d, B beats %0d, response flits %0d",
             error_count, aw_count, w_beat_total, b_count, resp_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic send_flit(input noc_flit flit);
    while (idle_bit) begin
      @(posedge clk);
      #1;
    end
    rx_valid = 1'b1;
    rx_flit  = flit;
    @(posedge clk);
    while (!rx_ready) begin
      @(posedge clk);
    end
    #1;
    rx_valid = 1'b0;
    rx_flit  = '0;
  endtask

  task automatic send_packet(input int p);
    noc_flit flit;
    flit                            = '0;
    flit.head                       = 1'b1;
    flit.body.header.packet_type    = NOC_WRITE_REQUEST;
    flit.body.header.destination_id = {ID_X, ID_Y};
    flit.body.header.source_id      = {src_x[p], src_y[p]};
    flit.body.header.vc             = VC;
    flit.body.header.tag            = tag[p];
    flit.body.header.burst_length   = len[p];
    flit.body.header.burst_size     = size[p];
    flit.body.header.address        = addr[p];
    send_flit(flit);
    for (int i = 0; i <= len[p]; i++) begin
      flit                                  = '0;
      flit.tail                             = (i == len[p]);
      flit.body.payload.payload.data        = seed[p] + i;
      flit.body.payload.payload.byte_enable = strb[p];
      send_flit(flit);
    end
  endtask

  task automatic check_response(input int p);
    noc_header header;
    header = tx_flit.body.header;
    if ({tx_flit.head, tx_flit.tail} !== 2'b11)
      report_mismatch("resp_head_tail", 2'b11, {tx_flit.head, tx_flit.tail});
    if (header.packet_type !== NOC_RESPONSE)
      report_mismatch("resp_type", NOC_RESPONSE, header.packet_type);
    if (header.destination_id !== {src_x[p], src_y[p]})
      report_mismatch("resp_dest", {src_x[p], src_y[p]}, header.destination_id);
    if (header.tag !== tag[p])
      report_mismatch("resp_tag", tag[p], header.tag);
    if (header.source_id !== {ID_X, ID_Y})
      report_mismatch("resp_source", {ID_X, ID_Y}, header.source_id);
    if (header.vc !== VC)
      report_mismatch("resp_vc", VC, header.vc);
    if (header.status !== resp[p])
      report_mismatch("resp_status", resp[p], header.status);
    if ({header.burst_length, header.burst_size, header.address, header.padding} !== '0)
      report_mismatch("resp_zero_fields", '0,
                      {header.burst_length, header.burst_size, header.address,
                       header.padding});
  endtask

  // AXI write target and stream monitor
  always @(posedge clk) begin : axi_target
    logic                         aw_bit;
    logic                         w_bit;
    logic                         tx_bit;
    logic                         gap_bit;
    logic [`NOC_AXI_ID_WIDTH-1:0] exp_id;
    logic [`NOC_DATA_WIDTH-1:0]   exp_data;
    if (!reset) begin
      if (!head_seen && (awvalid || wvalid || tx_valid))
        report_failure("a valid output rose before the first head flit was accepted");
      if (rx_valid && rx_ready && rx_flit.head)
        head_seen = 1'b1;
      if (awvalid && awready) begin
        if (aw_count >= NUM_PATTERNS) begin
          report_failure("AW beat seen after the last request");
        end else begin
          exp_id = {src_x[aw_count], src_y[aw_count], tag[aw_count]};
          if (awid !== exp_id)
            report_mismatch("aw_id", exp_id, awid);
          if (awaddr !== addr[aw_count])
            report_mismatch("aw_addr", addr[aw_count], awaddr);
          if (awlen !== len[aw_count])
            report_mismatch("aw_len", len[aw_count], awlen);
          if (awsize !== size[aw_count])
            report_mismatch("aw_size", size[aw_count], awsize);
          if (awburst !== 2'b01)
            report_mismatch("aw_burst", 2'b01, awburst);
          captured_awid[aw_count] = awid;
        end
        aw_count++;
      end
      if (wvalid && wready) begin
        if (w_burst_count >= NUM_PATTERNS) begin
          report_failure("W beat seen after the last burst");
        end else begin
          exp_data = seed[w_burst_count] + w_beat_index;
          if (wdata !== exp_data)
            report_mismatch("w_data", exp_data, wdata);
          if (wstrb !== strb[w_burst_count])
            report_mismatch("w_strb", strb[w_burst_count], wstrb);
          if (wlast !== (w_beat_index == len[w_burst_count]))
            report_mismatch("w_last", w_beat_index == len[w_burst_count], wlast);
        end
        w_beat_total++;
        if (wlast) begin
          w_burst_count++;
          w_beat_index = 0;
        end else begin
          w_beat_index++;
        end
      end
      if (bvalid && bready)
        b_count++;
      if (tx_valid && tx_ready) begin
        if (resp_count >= NUM_PATTERNS)
          report_failure("response flit seen after the last request");
        else
          check_response(resp_count);
        resp_count++;
      end
    end
    random_bit(aw_bit);
    random_bit(w_bit);
    random_bit(tx_bit);
    random_bit(gap_bit);
    idle_bit = gap_bit;
    #1;
    awready  = aw_bit;
    wready   = w_bit;
    tx_ready = tx_bit;
    // B only once both address and last data beat are in
    if (b_count < aw_count && b_count < w_burst_count && b_count < NUM_PATTERNS) begin
      bvalid = 1'b1;
      bid    = captured_awid[b_count];
      bresp  = resp[b_count];
    end else begin
      bvalid = 1'b0;
    end
  end

  initial begin
    cycle_count = 0;
    @(posedge clk);
    while (cycle_count < timeout_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    report_failure("timeout, the responses did not all arrive within the cycle limit");
    finish_run();
  end

  initial begin
    int total_flits;
    int base;
    clk            = 1'b0;
    reset          = 1'b1;
    rx_valid       = 1'b0;
    rx_flit        = '0;
    tx_ready       = 1'b0;
    awready        = 1'b0;
    wready         = 1'b0;
    bvalid         = 1'b0;
    bid            = '0;
    bresp          = '0;
    lfsr_state     = 32'h85b5_21c9;
    idle_bit       = 1'b0;
    head_seen      = 1'b0;
    error_count    = 0;
    aw_count       = 0;
    w_burst_count  = 0;
    w_beat_index   = 0;
    w_beat_total   = 0;
    b_count        = 0;
    resp_count     = 0;
    total_flits    = 0;
    expected_beats = 0;
    timeout_limit  = 1000;
    $readmemh("verif/write_patterns.txt", pattern_mem);
    if ($isunknown(pattern_mem[NUM_PATTERNS*NUM_FIELDS-1]))
      report_failure("pattern file holds fewer requests than expected");
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      base     = p * NUM_FIELDS;
      src_x[p] = pattern_mem[base][`NOC_COORD_WIDTH-1:0];
      src_y[p] = pattern_mem[base+1][`NOC_COORD_WIDTH-1:0];
      tag[p]   = pattern_mem[base+2][`NOC_TAG_WIDTH-1:0];
      addr[p]  = pattern_mem[base+3];
      len[p]   = pattern_mem[base+4][`NOC_LEN_WIDTH-1:0];
      size[p]  = pattern_mem[base+5][2:0];
      seed[p]  = pattern_mem[base+6];
      strb[p]  = pattern_mem[base+7][`NOC_STRB_WIDTH-1:0];
      resp[p]  = pattern_mem[base+8][1:0];
      total_flits    += len[p] + 2;
      expected_beats += len[p] + 1;
    end
    timeout_limit = 10 * total_flits + 200;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int p = 0; p < NUM_PATTERNS; p++) begin
      send_packet(p);
    end
    while (resp_count < NUM_PATTERNS) begin
      @(posedge clk);
    end
    // Quiet stretch to expose late duplicates
    repeat (20) @(posedge clk);
    if (aw_count != NUM_PATTERNS)
      report_mismatch("aw_count", NUM_PATTERNS, aw_count);
    if (w_burst_count != NUM_PATTERNS)
      report_mismatch("w_burst_count", NUM_PATTERNS, w_burst_count);
    if (w_beat_total != expected_beats)
      report_mismatch("w_beat_count", expected_beats, w_beat_total);
    if (b_count != NUM_PATTERNS)
      report_mismatch("b_count", NUM_PATTERNS, b_count);
    if (resp_count != NUM_PATTERNS)
      report_mismatch("resp_count", NUM_PATTERNS, resp_count);
    finish_run();
  end

endmodule

`default_nettype wire

//--- hw/noc_axi_write_adapter.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_axi_defines.svh"

module noc_axi_write_adapter (
  input  logic                          i_clk,
  input  logic                          i_reset,
  input  logic [`NOC_COORD_WIDTH-1:0]   i_id_x,
  input  logic [`NOC_COORD_WIDTH-1:0]   i_id_y,
  input  logic [`NOC_VC_WIDTH-1:0]      i_vc,
  input  logic                          i_rx_flit_valid,
  input  noc_axi_pkg::noc_flit          i_rx_flit,
  output logic                          o_rx_flit_ready,
  output logic                          o_tx_flit_valid,
  output noc_axi_pkg::noc_flit          o_tx_flit,
  input  logic                          i_tx_flit_ready,
  output logic                          o_awvalid,
  input  logic                          i_awready,
  output logic [`NOC_AXI_ID_WIDTH-1:0]  o_awid,
  output logic [`NOC_ADDR_WIDTH-1:0]    o_awaddr,
  output logic [`NOC_LEN_WIDTH-1:0]     o_awlen,
  output logic [2:0]                    o_awsize,
  output logic [1:0]                    o_awburst,
  output logic                          o_wvalid,
  input  logic                          i_wready,
  output logic [`NOC_DATA_WIDTH-1:0]    o_wdata,
  output logic [`NOC_STRB_WIDTH-1:0]    o_wstrb,
  output logic                          o_wlast,
  input  logic                          i_bvalid,
  output logic                          o_bready,
  input  logic [`NOC_AXI_ID_WIDTH-1:0]  i_bid,
  input  logic [1:0]                    i_bresp
);
  import noc_axi_pkg::*;

  // Request path
  noc_packet_if request_if ();

  noc_axi_id awid_fields;

  // Requester location and tag ride in AWID
  assign awid_fields.location = request_if.header.source_id;
  assign awid_fields.tag      = request_if.header.tag;

  assign o_awvalid               = request_if.header_valid;
  assign request_if.header_ready = i_awready;
  assign o_awid                  = awid_fields;
  assign o_awaddr                = request_if.header.address;
  assign o_awlen                 = request_if.header.burst_length;
  assign o_awsize                = request_if.header.burst_size;
  assign o_awburst               = NOC_AXI_BURST_INCR;

  assign o_wvalid                 = request_if.payload_valid;
  assign request_if.payload_ready = i_wready;
  assign o_wdata                  = request_if.payload.data;
  assign o_wstrb                  = request_if.payload.byte_enable;
  assign o_wlast                  = request_if.payload_last;

  noc_packet_deserializer u_deserializer (
    .i_clk        (i_clk           ),
    .i_reset      (i_reset         ),
    .i_flit_valid (i_rx_flit_valid ),
    .i_flit       (i_rx_flit       ),
    .o_flit_ready (o_rx_flit_ready ),
    .packet_if    (request_if      )
  );

  // Response path
  noc_packet_if response_if ();

  noc_axi_id bid_fields;
  noc_header response_header;

  assign bid_fields = i_bid;

  always_comb begin
    response_header                = '0;
    response_header.packet_type    = NOC_RESPONSE;
    response_header.destination_id = bid_fields.location;
    response_header.tag            = bid_fields.tag;
    response_header.source_id.x    = i_id_x;
    response_header.source_id.y    = i_id_y;
    response_header.vc             = i_vc;
    response_header.status         = i_bresp;
  end

  assign response_if.header_valid = i_bvalid;
  assign o_bready                 = response_if.header_ready;
  assign response_if.header       = response_header;

  // No data travels with a write response
  assign response_if.payload_valid = 1'b0;
  assign response_if.payload       = '0;
  assign response_if.payload_last  = 1'b0;

  noc_packet_serializer u_serializer (
    .i_clk        (i_clk           ),
    .i_reset      (i_reset         ),
    .packet_if    (response_if     ),
    .o_flit_valid (o_tx_flit_valid ),
    .o_flit       (o_tx_flit       ),
    .i_flit_ready (i_tx_flit_ready )
  );

endmodule

`default_nettype wire

//--- hw/noc_packet_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module noc_packet_serializer (
  input  logic                 i_clk,
  input  logic                 i_reset,
  noc_packet_if.receiver       packet_if,
  output logic                 o_flit_valid,
  output noc_axi_pkg::noc_flit o_flit,
  input  logic                 i_flit_ready
);
  import noc_axi_pkg::*;

  logic    flit_valid;
  noc_flit flit_q;
  logic    header_accept;

  // New header may enter as the held flit leaves
  assign packet_if.header_ready = !flit_valid || i_flit_ready;
  assign header_accept          = packet_if.header_valid && packet_if.header_ready;

  // Responses have no payload
  assign packet_if.payload_ready = 1'b1;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      flit_valid <= 1'b0;
    end else if (header_accept) begin
      flit_valid <= 1'b1;
    end else if (i_flit_ready) begin
      flit_valid <= 1'b0;
    end
  end

  // Single flit packet with head and tail both set
  always_ff @(posedge i_clk) begin
    if (header_accept) begin
      flit_q.head        <= 1'b1;
      flit_q.tail        <= 1'b1;
      flit_q.body.header <= packet_if.header;
    end
  end

  assign o_flit_valid = flit_valid;
  assign o_flit       = flit_q;

endmodule

`default_nettype wire

//--- hw/noc_packet_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

module noc_packet_deserializer (
  input  logic                 i_clk,
  input  logic                 i_reset,
  input  logic                 i_flit_valid,
  input  noc_axi_pkg::noc_flit i_flit,
  output logic                 o_flit_ready,
  noc_packet_if.sender         packet_if
);
  import noc_axi_pkg::*;

  logic       expect_head;
  logic       header_valid;
  noc_header  header_q;
  logic       payload_valid;
  noc_payload payload_q;
  logic       payload_last_q;
  logic       header_free;
  logic       payload_free;
  logic       flit_accept;
  logic       head_accept;
  logic       payload_accept;

  // Register can take a flit if empty or draining this cycle
  assign header_free  = !header_valid || packet_if.header_ready;
  assign payload_free = !payload_valid || packet_if.payload_ready;
  assign o_flit_ready = expect_head ? header_free : payload_free;

  assign flit_accept    = i_flit_valid && o_flit_ready;
  assign head_accept    = flit_accept && expect_head;
  assign payload_accept = flit_accept && !expect_head;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      expect_head   <= 1'b1;
      header_valid  <= 1'b0;
      payload_valid <= 1'b0;
    end else begin
      // Tail flit ends the packet so the next flit is a head
      if (flit_accept) begin
        expect_head <= i_flit.tail;
      end

      if (head_accept) begin
        header_valid <= 1'b1;
      end else if (packet_if.header_ready) begin
        header_valid <= 1'b0;
      end

      if (payload_accept) begin
        payload_valid <= 1'b1;
      end else if (packet_if.payload_ready) begin
        payload_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (head_accept) begin
      header_q <= i_flit.body.header;
    end
    if (payload_accept) begin
      payload_q      <= i_flit.body.payload.payload;
      payload_last_q <= i_flit.tail;
    end
  end

  assign packet_if.header_valid  = header_valid;
  assign packet_if.header        = header_q;
  assign packet_if.payload_valid = payload_valid;
  assign packet_if.payload       = payload_q;
  assign packet_if.payload_last  = payload_last_q;

endmodule

`default_nettype wire

//--- hw/noc_packet_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_axi_defines.svh"

interface noc_packet_if;
  import noc_axi_pkg::*;

  logic       header_valid;
  logic       header_ready;
  noc_header  header;
  logic       payload_valid;
  logic       payload_ready;
  noc_payload payload;
  logic       payload_last;

  modport sender (
    output header_valid, header,
    input  header_ready,
    output payload_valid, payload, payload_last,
    input  payload_ready
  );

  modport receiver (
    input  header_valid, header,
    output header_ready,
    input  payload_valid, payload, payload_last,
    output payload_ready
  );

endinterface

`default_nettype wire

//--- hw/noc_axi_pkg.sv
`default_nettype none

`include "noc_axi_defines.svh"

package noc_axi_pkg;

  localparam logic [1:0] NOC_AXI_BURST_INCR = 2'b01;

  typedef struct packed {
    logic [`NOC_COORD_WIDTH-1:0] x;
    logic [`NOC_COORD_WIDTH-1:0] y;
  } noc_location_id;

  typedef enum logic [0:0] {
    NOC_WRITE_REQUEST = 1'b0,
    NOC_RESPONSE      = 1'b1
  } noc_packet_type;

  // Layout of AWID/BID
  typedef struct packed {
    noc_location_id            location;
    logic [`NOC_TAG_WIDTH-1:0] tag;
  } noc_axi_id;

  typedef struct packed {
    noc_packet_type                   packet_type;
    noc_location_id                   destination_id;
    noc_location_id                   source_id;
    logic [`NOC_VC_WIDTH-1:0]         vc;
    logic [`NOC_TAG_WIDTH-1:0]        tag;
    logic [`NOC_LEN_WIDTH-1:0]        burst_length;
    logic [2:0]                       burst_size;
    logic [`NOC_ADDR_WIDTH-1:0]       address;
    logic [1:0]                       status;
    logic [`NOC_HEADER_PAD_WIDTH-1:0] padding;
  } noc_header;

  typedef struct packed {
    logic [`NOC_DATA_WIDTH-1:0] data;
    logic [`NOC_STRB_WIDTH-1:0] byte_enable;
  } noc_payload;

  // Payload view zero padded up to the flit body width
  typedef struct packed {
    logic [`NOC_PAYLOAD_PAD_WIDTH-1:0] padding;
    noc_payload                        payload;
  } noc_payload_word;

  // Header flit and payload flit share one body word
  typedef union packed {
    noc_header       header;
    noc_payload_word payload;
  } noc_flit_body;

  typedef struct packed {
    logic         head;
    logic         tail;
    noc_flit_body body;
  } noc_flit;

endpackage

`default_nettype wire

//--- hw/noc_axi_defines.svh
`ifndef NOC_AXI_DEFINES_SVH
`define NOC_AXI_DEFINES_SVH

`define NOC_ADDR_WIDTH        32
`define NOC_DATA_WIDTH        32
`define NOC_STRB_WIDTH        4
`define NOC_COORD_WIDTH       2
`define NOC_TAG_WIDTH         4
`define NOC_LEN_WIDTH         8
`define NOC_VC_WIDTH          1

// AXI ID carries requester location and tag
`define NOC_AXI_ID_WIDTH      (2 * `NOC_COORD_WIDTH + `NOC_TAG_WIDTH)

`define NOC_FLIT_BODY_WIDTH   64
`define NOC_HEADER_PAD_WIDTH  (`NOC_FLIT_BODY_WIDTH - 10 - `NOC_AXI_ID_WIDTH \
                               - `NOC_VC_WIDTH - `NOC_LEN_WIDTH - `NOC_ADDR_WIDTH)
`define NOC_PAYLOAD_PAD_WIDTH (`NOC_FLIT_BODY_WIDTH - `NOC_DATA_WIDTH - `NOC_STRB_WIDTH)

`endif
